// File: common/rv_pkg.sv
package rv_pkg;

  localparam int XLEN      = 32;
  localparam int INST_W    = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;
  localparam int SHAMT_W   = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [INST_W-1:0]    inst_t;

  // Instruction field positions and widths
  localparam int OPC_LSB = 0;
  localparam int OPC_W   = 7;
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int F3_W    = 3;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;
  localparam int F7_W    = 7;

  // Major opcodes handled by this core
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;

  localparam logic [F7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [F7_W-1:0] F7_ALT  = 7'b0100000;

  localparam addr_t PC_STEP = 4;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_op_e;

endpackage

// File: common/issue_if.sv
interface issue_if import rv_pkg::*; ();

  logic     valid;
  logic     ready;
  addr_t    pc;
  xlen_t    src1;
  // Second ALU operand, or rs2 data for a branch
  xlen_t    src2;
  xlen_t    imm;
  alu_op_e  alu_op;
  br_op_e   br_op;
  reg_idx_t rd;
  logic     reg_write_en;
  logic     illegal;

  modport decode (
    output valid, pc, src1, src2, imm, alu_op, br_op, rd, reg_write_en, illegal,
    input  ready
  );

  modport exec (
    input  valid, pc, src1, src2, imm, alu_op, br_op, rd, reg_write_en, illegal,
    output ready
  );

endinterface

// File: common/result_if.sv
interface result_if import rv_pkg::*; ();

  logic     valid;
  logic     ready;
  addr_t    pc;
  addr_t    next_pc;
  xlen_t    wdata;
  reg_idx_t rd;
  logic     reg_write_en;
  logic     taken;
  logic     illegal;

  modport exec (
    output valid, pc, next_pc, wdata, rd, reg_write_en, taken, illegal,
    input  ready
  );

  modport writeback (
    input  valid, pc, next_pc, wdata, rd, reg_write_en, taken, illegal,
    output ready
  );

endinterface

// File: exu/alu.sv
module alu import rv_pkg::*; (
  input  alu_op_e op,
  input  xlen_t   a,
  input  xlen_t   b,
  output xlen_t   result,
  output logic    zero
);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = b[SHAMT_W-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SRL: begin
        result = a >> shamt;
      end
      ALU_SRA: begin
        result = $signed(a) >>> shamt;
      end
      ALU_SLT: begin
        result = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      // LUI immediate goes straight through
      default: begin
        result = b;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: design/reg_file.sv
module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_addr,
  input  reg_idx_t rs2_addr,
  output xlen_t    rs1_data,
  output xlen_t    rs2_data,
  input  logic     reg_write_en,
  input  reg_idx_t rd,
  input  xlen_t    wdata
);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write_en && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: design/decode_stage.sv
module decode_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_valid,
  output logic     inst_ready,
  input  inst_t    inst,
  input  addr_t    inst_pc,
  output reg_idx_t rs1_addr,
  output reg_idx_t rs2_addr,
  input  xlen_t    rs1_data,
  input  xlen_t    rs2_data,
  input  reg_idx_t exec_busy_rd,
  input  reg_idx_t wb_busy_rd,
  issue_if.decode  issue
);

  logic             dec_valid;
  inst_t            dec_inst;
  addr_t            dec_pc;
  logic [OPC_W-1:0] opcode;
  logic [F3_W-1:0]  funct3;
  logic [F7_W-1:0]  funct7;
  xlen_t            imm_i;
  xlen_t            imm_u;
  xlen_t            imm_b;
  xlen_t            imm;
  alu_op_e          alu_op;
  br_op_e           br_op;
  logic             use_rs1;
  logic             use_rs2;
  logic             use_imm;
  logic             writes_rd;
  logic             illegal;
  logic             rs1_hazard;
  logic             rs2_hazard;

  assign inst_ready = !dec_valid || (issue.valid && issue.ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (inst_ready) begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid && inst_ready) begin
      dec_inst <= inst;
      dec_pc   <= inst_pc;
    end
  end

  assign opcode   = dec_inst[OPC_LSB +: OPC_W];
  assign funct3   = dec_inst[F3_LSB +: F3_W];
  assign funct7   = dec_inst[F7_LSB +: F7_W];
  assign rs1_addr = dec_inst[RS1_LSB +: REG_IDX_W];
  assign rs2_addr = dec_inst[RS2_LSB +: REG_IDX_W];

  assign imm_i = {{20{dec_inst[31]}}, dec_inst[31:20]};
  assign imm_u = {dec_inst[31:12], 12'b0};
  assign imm_b = {{19{dec_inst[31]}}, dec_inst[31], dec_inst[7], dec_inst[30:25],
                  dec_inst[11:8], 1'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    br_op     = BR_NONE;
    imm       = imm_i;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    use_imm   = 1'b1;
    writes_rd = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        use_imm   = 1'b0;
        writes_rd = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: alu_op = ALU_ADD;
          {F7_ALT,  3'b000}: alu_op = ALU_SUB;
          {F7_BASE, 3'b001}: alu_op = ALU_SLL;
          {F7_BASE, 3'b010}: alu_op = ALU_SLT;
          {F7_BASE, 3'b011}: alu_op = ALU_SLTU;
          {F7_BASE, 3'b100}: alu_op = ALU_XOR;
          {F7_BASE, 3'b101}: alu_op = ALU_SRL;
          {F7_ALT,  3'b101}: alu_op = ALU_SRA;
          {F7_BASE, 3'b110}: alu_op = ALU_OR;
          {F7_BASE, 3'b111}: alu_op = ALU_AND;
          // M extension lands here too
          default:           illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            alu_op  = ALU_SLL;
            illegal = (funct7 != F7_BASE);
          end
          default: begin
            alu_op  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
        endcase
      end
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        imm       = imm_u;
        writes_rd = 1'b1;
      end
      OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_imm = 1'b0;
        imm     = imm_b;
        case (funct3)
          3'b000:  br_op = BR_EQ;
          3'b001:  br_op = BR_NE;
          3'b100:  br_op = BR_LT;
          3'b101:  br_op = BR_GE;
          3'b110:  br_op = BR_LTU;
          3'b111:  br_op = BR_GEU;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // Busy indexes are zero when idle, so x0 must never match
  assign rs1_hazard = use_rs1 && (rs1_addr != '0) &&
                      ((rs1_addr == exec_busy_rd) || (rs1_addr == wb_busy_rd));
  assign rs2_hazard = use_rs2 && (rs2_addr != '0) &&
                      ((rs2_addr == exec_busy_rd) || (rs2_addr == wb_busy_rd));

  assign issue.valid        = dec_valid && !rs1_hazard && !rs2_hazard;
  assign issue.pc           = dec_pc;
  assign issue.src1         = rs1_data;
  assign issue.src2         = use_imm ? imm : rs2_data;
  assign issue.imm          = imm;
  assign issue.alu_op       = alu_op;
  assign issue.br_op        = br_op;
  assign issue.rd           = dec_inst[RD_LSB +: REG_IDX_W];
  assign issue.reg_write_en = writes_rd;
  assign issue.illegal      = illegal;

endmodule

// File: exu/exec_stage.sv
module exec_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  issue_if.exec    issue,
  result_if.exec   result,
  output reg_idx_t exec_busy_rd
);

  logic     ex_valid;
  addr_t    ex_pc;
  xlen_t    ex_src1;
  xlen_t    ex_src2;
  xlen_t    ex_imm;
  alu_op_e  ex_alu_op;
  br_op_e   ex_br_op;
  reg_idx_t ex_rd;
  logic     ex_we;
  logic     ex_illegal;
  alu_op_e  alu_sel;
  xlen_t    alu_result;
  logic     alu_zero;
  logic     taken;
  logic     write_en;

  assign issue.ready = !ex_valid || result.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (issue.ready) begin
      ex_valid <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid && issue.ready) begin
      ex_pc      <= issue.pc;
      ex_src1    <= issue.src1;
      ex_src2    <= issue.src2;
      ex_imm     <= issue.imm;
      ex_alu_op  <= issue.alu_op;
      ex_br_op   <= issue.br_op;
      ex_rd      <= issue.rd;
      ex_we      <= issue.reg_write_en;
      ex_illegal <= issue.illegal;
    end
  end

  // Branches reuse the ALU as comparator
  always_comb begin
    case (ex_br_op)
      BR_EQ, BR_NE:   alu_sel = ALU_SUB;
      BR_LT, BR_GE:   alu_sel = ALU_SLT;
      BR_LTU, BR_GEU: alu_sel = ALU_SLTU;
      default:        alu_sel = ex_alu_op;
    endcase
  end

  alu u_alu (
    .op     (alu_sel),
    .a      (ex_src1),
    .b      (ex_src2),
    .result (alu_result),
    .zero   (alu_zero)
  );

  always_comb begin
    case (ex_br_op)
      BR_EQ:          taken = alu_zero;
      BR_NE:          taken = !alu_zero;
      BR_LT, BR_LTU:  taken = alu_result[0];
      BR_GE, BR_GEU:  taken = !alu_result[0];
      default:        taken = 1'b0;
    endcase
  end

  assign write_en     = ex_we && (ex_br_op == BR_NONE) && !ex_illegal;
  assign exec_busy_rd = (ex_valid && write_en) ? ex_rd : '0;

  assign result.valid        = ex_valid;
  assign result.pc           = ex_pc;
  assign result.next_pc      = taken ? ex_pc + ex_imm : ex_pc + PC_STEP;
  assign result.wdata        = alu_result;
  assign result.rd           = ex_rd;
  assign result.reg_write_en = write_en;
  assign result.taken        = taken;
  assign result.illegal      = ex_illegal;

endmodule

// File: design/wb_stage.sv
module wb_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  result_if.writeback result,
  output logic        commit_valid,
  input  logic        commit_ready,
  output addr_t       commit_pc,
  output reg_idx_t    commit_rd,
  output xlen_t       commit_wdata,
  output logic        commit_we,
  output addr_t       commit_next_pc,
  output logic        commit_taken,
  output logic        commit_illegal,
  output logic        reg_write_en,
  output reg_idx_t    rd,
  output xlen_t       wdata,
  output reg_idx_t    wb_busy_rd
);

  assign result.ready = !commit_valid || commit_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else if (result.ready) begin
      commit_valid <= result.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (result.valid && result.ready) begin
      commit_pc      <= result.pc;
      commit_rd      <= result.rd;
      commit_wdata   <= result.wdata;
      commit_we      <= result.reg_write_en;
      commit_next_pc <= result.next_pc;
      commit_taken   <= result.taken;
      commit_illegal <= result.illegal;
    end
  end

  // Register file updates on the commit edge
  assign reg_write_en = commit_valid && commit_ready && commit_we;
  assign rd           = commit_rd;
  assign wdata        = commit_wdata;
  assign wb_busy_rd   = (commit_valid && commit_we) ? commit_rd : '0;

endmodule

// File: design/rv_exec_core.sv
module rv_exec_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_valid,
  output logic     inst_ready,
  input  inst_t    inst,
  input  addr_t    inst_pc,
  output logic     commit_valid,
  input  logic     commit_ready,
  output addr_t    commit_pc,
  output reg_idx_t commit_rd,
  output xlen_t    commit_wdata,
  output logic     commit_we,
  output addr_t    commit_next_pc,
  output logic     commit_taken,
  output logic     commit_illegal
);

  reg_idx_t rs1_addr;
  reg_idx_t rs2_addr;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  logic     reg_write_en;
  reg_idx_t rd;
  xlen_t    wdata;
  reg_idx_t exec_busy_rd;
  reg_idx_t wb_busy_rd;

  issue_if  issue ();
  result_if result ();

  decode_stage u_decode (
    .clk, .rst, .inst_valid, .inst_ready, .inst, .inst_pc,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .exec_busy_rd, .wb_busy_rd,
    .issue (issue.decode)
  );

  reg_file u_reg_file (
    .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .reg_write_en, .rd, .wdata
  );

  exec_stage u_exec (
    .clk, .rst,
    .issue  (issue.exec),
    .result (result.exec),
    .exec_busy_rd
  );

  wb_stage u_wb (
    .clk, .rst,
    .result (result.writeback),
    .commit_valid, .commit_ready, .commit_pc, .commit_rd, .commit_wdata,
    .commit_we, .commit_next_pc, .commit_taken, .commit_illegal,
    .reg_write_en, .rd, .wdata, .wb_busy_rd
  );

endmodule

// File: bench/tb_rv_exec_core.sv
module tb_rv_exec_core import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_ENTRIES = 64;

  logic     clk;
  logic     rst;
  logic     inst_valid;
  logic     inst_ready;
  inst_t    inst;
  addr_t    inst_pc;
  logic     commit_valid;
  logic     commit_ready;
  addr_t    commit_pc;
  reg_idx_t commit_rd;
  xlen_t    commit_wdata;
  logic     commit_we;
  addr_t    commit_next_pc;
  logic     commit_taken;
  logic     commit_illegal;

  inst_t    tbl_inst    [MAX_ENTRIES];
  addr_t    tbl_pc      [MAX_ENTRIES];
  reg_idx_t exp_rd      [MAX_ENTRIES];
  xlen_t    exp_wdata   [MAX_ENTRIES];
  logic     exp_we      [MAX_ENTRIES];
  addr_t    exp_next_pc [MAX_ENTRIES];
  logic     exp_taken   [MAX_ENTRIES];
  logic     exp_illegal [MAX_ENTRIES];
  int       n_entries;

  integer        seed = 32'hed2e;
  int            chk_idx;
  int            cycle;
  int            accept_cycle;
  logic          seen_commit;
  logic          held;
  logic [103:0]  held_rec;

  rv_exec_core dut (
    .clk, .rst, .inst_valid, .inst_ready, .inst, .inst_pc,
    .commit_valid, .commit_ready, .commit_pc, .commit_rd, .commit_wdata,
    .commit_we, .commit_next_pc, .commit_taken, .commit_illegal
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first mismatch");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_field(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      report_mismatch($sformatf("entry %0d %s is %h, expected %h", chk_idx, what, got, exp));
  endtask

  // Instruction encoders take operands in assembly order
  function automatic inst_t enc_r(input int f7, input int f3, input int rd,
                                  input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic inst_t enc_i(input int f3, input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic inst_t enc_u(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic inst_t enc_b(input int f3, input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic add_entry(input inst_t word, input int rd, input xlen_t wdata,
                           input logic we, input addr_t next_pc, input logic tk,
                           input logic ill);
    tbl_inst[n_entries]    = word;
    tbl_pc[n_entries]      = 32'h100 + 4 * n_entries;
    exp_rd[n_entries]      = rd[4:0];
    exp_wdata[n_entries]   = wdata;
    exp_we[n_entries]      = we;
    exp_next_pc[n_entries] = next_pc;
    exp_taken[n_entries]   = tk;
    exp_illegal[n_entries] = ill;
    n_entries++;
  endtask

  task automatic add_alu(input inst_t word, input int rd, input xlen_t wdata);
    add_entry(word, rd, wdata, 1'b1, 32'h100 + 4 * n_entries + 4, 1'b0, 1'b0);
  endtask

  task automatic add_branch(input inst_t word, input logic tk, input addr_t next_pc);
    add_entry(word, 0, 32'h0, 1'b0, next_pc, tk, 1'b0);
  endtask

  task automatic add_illegal(input inst_t word);
    add_entry(word, 0, 32'h0, 1'b0, 32'h100 + 4 * n_entries + 4, 1'b0, 1'b1);
  endtask

  task automatic build_table();
    // Dependent chain starting at pc 0x100
    add_alu(enc_i(0, 1, 0, 5), 1, 32'h5);
    add_alu(enc_r(0, 0, 2, 1, 1), 2, 32'hA);
    add_alu(enc_r(32, 0, 3, 2, 1), 3, 32'h5);
    add_alu(enc_i(0, 4, 0, -8), 4, 32'hFFFF_FFF8);
    add_alu(enc_i(5, 5, 4, 'h401), 5, 32'hFFFF_FFFC);
    add_alu(enc_i(5, 6, 4, 28), 6, 32'h0000_000F);
    add_alu(enc_i(1, 7, 1, 3), 7, 32'h28);
    add_alu(enc_r(0, 2, 8, 4, 1), 8, 32'h1);
    add_alu(enc_r(0, 3, 9, 4, 1), 9, 32'h0);
    add_alu(enc_i(2, 10, 4, 3), 10, 32'h1);
    add_alu(enc_i(3, 11, 1, -1), 11, 32'h1);
    add_alu(enc_r(0, 4, 12, 2, 1), 12, 32'hF);
    add_alu(enc_i(4, 13, 1, 'hFF), 13, 32'hFA);
    add_alu(enc_r(0, 6, 14, 2, 1), 14, 32'hF);
    add_alu(enc_i(6, 15, 1, 'h30), 15, 32'h35);
    add_alu(enc_r(0, 7, 16, 4, 2), 16, 32'h8);
    add_alu(enc_i(7, 17, 4, 'h7C), 17, 32'h78);
    add_alu(enc_r(0, 1, 18, 1, 3), 18, 32'hA0);
    add_alu(enc_r(0, 5, 19, 4, 1), 19, 32'h07FF_FFFF);
    add_alu(enc_r(32, 5, 20, 4, 1), 20, 32'hFFFF_FFFF);
    add_alu(enc_u(21, 'h12345), 21, 32'h1234_5000);
    // Write to x0 commits but a later read still sees zero
    add_alu(enc_i(0, 0, 1, 7), 0, 32'hC);
    add_alu(enc_r(0, 0, 22, 0, 1), 22, 32'h5);
    add_alu(enc_r(0, 0, 23, 21, 4), 23, 32'h1234_4FF8);
    // Branches from 0x160 go taken then not taken per kind
    add_branch(enc_b(0, 1, 3, 16), 1'b1, 32'h170);
    add_branch(enc_b(0, 1, 2, 16), 1'b0, 32'h168);
    add_branch(enc_b(1, 1, 2, -8), 1'b1, 32'h160);
    add_branch(enc_b(1, 1, 3, 8), 1'b0, 32'h170);
    add_branch(enc_b(4, 4, 1, 12), 1'b1, 32'h17C);
    add_branch(enc_b(4, 1, 4, 12), 1'b0, 32'h178);
    add_branch(enc_b(5, 1, 4, 20), 1'b1, 32'h18C);
    add_branch(enc_b(5, 4, 1, 20), 1'b0, 32'h180);
    add_branch(enc_b(6, 1, 4, 32), 1'b1, 32'h1A0);
    add_branch(enc_b(6, 4, 1, 32), 1'b0, 32'h188);
    add_branch(enc_b(7, 4, 1, -64), 1'b1, 32'h148);
    add_branch(enc_b(7, 1, 4, -64), 1'b0, 32'h190);
    // Unknown opcode followed by MUL
    add_illegal(32'h0000_007F);
    add_illegal(enc_r(1, 0, 24, 1, 2));
    add_alu(enc_i(0, 25, 22, 1), 25, 32'h6);
    add_alu(enc_r(32, 0, 26, 0, 1), 26, 32'hFFFF_FFFB);
    add_alu(enc_r(0, 2, 27, 1, 26), 27, 32'h0);
    add_alu(enc_r(0, 3, 28, 1, 26), 28, 32'h1);
  endtask

  function automatic logic [103:0] commit_record();
    return {commit_pc, commit_rd, commit_wdata, commit_we, commit_next_pc,
            commit_taken, commit_illegal};
  endfunction

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    inst_pc      = '0;
    commit_ready = 1'b1;
    n_entries    = 0;
    build_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (inst_ready === 1'b1 && commit_valid === 1'b0) else
      report_mismatch("inst_ready low or commit_valid high right after reset");
    for (int i = 0; i < n_entries; i++) begin
      if (($random(seed) & 3) == 0) begin
        inst_valid <= 1'b0;
        repeat (1 + ($random(seed) & 1)) @(posedge clk);
      end
      inst_valid <= 1'b1;
      inst       <= tbl_inst[i];
      inst_pc    <= tbl_pc[i];
      @(posedge clk);
      while (!inst_ready) @(posedge clk);
    end
    inst_valid <= 1'b0;
    wait (chk_idx == n_entries);
    // Idle a few cycles so a duplicate commit would show up
    repeat (8) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

  // Back-pressure stays off until the first commit
  always @(posedge clk) begin
    if (rst || !seen_commit) begin
      commit_ready <= 1'b1;
    end else begin
      commit_ready <= (($random(seed) % 3) != 0);
    end
  end

  initial begin
    chk_idx      = 0;
    cycle        = 0;
    accept_cycle = -1;
    seen_commit  = 1'b0;
    held         = 1'b0;
    held_rec     = '0;
  end

  always @(posedge clk) begin
    if (cycle > 40 * n_entries + 200) begin
      report_error("timeout, not all instructions committed in time");
    end
    if (!rst) begin
      if (inst_valid && inst_ready && accept_cycle < 0) begin
        accept_cycle = cycle;
      end
      if (commit_valid && !seen_commit) begin
        assert (cycle - accept_cycle == 3) else
          report_mismatch($sformatf("first commit after %0d cycles, expected 3",
                                    cycle - accept_cycle));
        seen_commit <= 1'b1;
      end
      if (held) begin
        assert (commit_valid === 1'b1 && commit_record() === held_rec) else
          report_mismatch("commit record changed while stalled");
      end
      held     = commit_valid && !commit_ready;
      held_rec = commit_record();
      if (commit_valid && commit_ready) begin
        assert (chk_idx < n_entries) else
          report_error("more commits came out than instructions were sent");
        check_field("pc", commit_pc, tbl_pc[chk_idx]);
        check_field("next_pc", commit_next_pc, exp_next_pc[chk_idx]);
        check_field("taken", 32'(commit_taken), 32'(exp_taken[chk_idx]));
        check_field("we", 32'(commit_we), 32'(exp_we[chk_idx]));
        check_field("illegal", 32'(commit_illegal), 32'(exp_illegal[chk_idx]));
        if (exp_we[chk_idx]) begin
          check_field("rd", 32'(commit_rd), 32'(exp_rd[chk_idx]));
          check_field("wdata", commit_wdata, exp_wdata[chk_idx]);
        end
        chk_idx = chk_idx + 1;
      end
    end
    cycle = cycle + 1;
  end

endmodule

// File: compile.f
common/rv_pkg.sv
common/issue_if.sv
common/result_if.sv
exu/alu.sv
design/reg_file.sv
design/decode_stage.sv
exu/exec_stage.sv
design/wb_stage.sv
design/rv_exec_core.sv
bench/tb_rv_exec_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_rv_exec_core
./obj_dir/Vtb_rv_exec_core | tee sim.log
if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi
echo "Simulation finished cleanly"
